//--- hdl/arb_pkg.sv
// shared sizes and vector types for the output scheduler, imported by RTL and bench
`default_nettype none

package arb_pkg;

    // switch geometry
    localparam int port_count = 8;                    // input queues
    localparam int pri_w      = 4;                    // one priority or weight value
    localparam int port_w     = $clog2(port_count);   // port index
    localparam int pri_bus_w  = port_count * pri_w;   // packed priority bus

    // one bit wider than a weight so a full turn of 16 grants fits
    localparam int credit_w   = pri_w + 1;

    // one request bit per port
    typedef logic [port_count-1:0] req_vec_t;

    // priority in fixed mode, weight in WRR mode
    typedef logic [pri_w-1:0] pri_t;

    // port i sits in bits i*pri_w +: pri_w
    typedef logic [pri_bus_w-1:0] pri_bus_t;

    typedef logic [port_w-1:0] port_idx_t;  // port number

    // grants taken in the current WRR turn
    typedef logic [credit_w-1:0] credit_t;

endpackage : arb_pkg

`default_nettype wire

//--- hdl/fixed_priority_pick.sv
// combinational fixed-priority picker, highest priority value wins, lowest index on ties
`timescale 1ns/1ps
`default_nettype none

module fixed_priority_pick (
    input  wire arb_pkg::req_vec_t  request_signals,
    input  wire arb_pkg::pri_t      prio [arb_pkg::port_count],
    output arb_pkg::port_idx_t      pick,
    output logic                    any
);

    import arb_pkg::*;

    port_idx_t best_idx;    // best requester seen so far
    pri_t      best_pri;    // its priority
    logic      have_best;   // set once the first requester is found

    // linear scan from port 0 upward
    // only a strictly greater priority replaces the current best,
    // so equal priorities keep the lower index
    always_comb begin
        best_idx  = '0;
        best_pri  = '0;
        have_best = 1'b0;
        for (int i = 0; i < port_count; i++) begin
            if (request_signals[i]) begin
                if (!have_best || (prio[i] > best_pri)) begin
                    best_idx  = port_idx_t'(i);
                    best_pri  = prio[i];
                    have_best = 1'b1;
                end
            end
        end
    end

    // index 0 when nobody asks
    assign pick = best_idx;

    assign any = |request_signals;  // same as have_best, cheaper

endmodule : fixed_priority_pick

`default_nettype wire

//--- hdl/wrr_scheduler.sv
// weighted round robin picker with ring pointer and credit counter, state updates each clock
`timescale 1ns/1ps
`default_nettype none

module wrr_scheduler (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     enable,           // high in WRR mode
    input  wire arb_pkg::req_vec_t  request_signals,
    input  wire arb_pkg::pri_t      prio [arb_pkg::port_count],
    output arb_pkg::port_idx_t      pick,
    output logic                    any
);

    import arb_pkg::*;

    // registered state
    port_idx_t ptr;       // port holding the current turn
    credit_t   used;      // grants already given in this turn
    logic      mode_q;    // enable from the previous edge

    // state after the mode-change clear
    logic      clear;
    port_idx_t cur;
    credit_t   used_eff;

    // decisions
    logic      stay;       // current port keeps the turn
    logic      ring_found;
    port_idx_t ring_pick;  // first requester after cur, wrapping

    // next state
    port_idx_t ptr_d;
    credit_t   used_d;

    // fresh start whenever the mode is off or was just switched
    assign clear    = !enable || (enable != mode_q);
    assign cur      = clear ? port_idx_t'(0) : ptr;
    assign used_eff = clear ? credit_t'(0) : used;

    assign any = |request_signals;

    // turn continues while the port still asks and credit is left
    // weight w gives w+1 grants in a row
    assign stay = request_signals[cur] && (used_eff <= credit_t'(prio[cur]));

    // ring search cur+1 .. cur+port_count, the last step lands back on cur
    // so a lone requester renews its own turn without a gap
    always_comb begin
        port_idx_t idx;
        ring_found = 1'b0;
        ring_pick  = cur;
        for (int off = 1; off <= port_count; off++) begin
            idx = port_idx_t'((int'(cur) + off) % port_count);
            if (!ring_found && request_signals[idx]) begin
                ring_found = 1'b1;
                ring_pick  = idx;
            end
        end
    end

    assign pick = stay ? cur : ring_pick;

    // next pointer and credit
    always_comb begin
        ptr_d  = cur;        // no request: hold (after any clear)
        used_d = used_eff;
        if (stay) begin
            used_d = used_eff + credit_t'(1);
        end else if (ring_found) begin
            ptr_d  = ring_pick;
            used_d = credit_t'(1);   // this grant counts toward the new turn
        end
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            ptr    <= '0;
            used   <= '0;
            mode_q <= 1'b0;
        end else begin
            mode_q <= enable;
            if (!enable) begin
                // idle in fixed mode
                ptr  <= '0;
                used <= '0;
            end else begin
                ptr  <= ptr_d;
                used <= used_d;
            end
        end
    end

endmodule : wrr_scheduler

`default_nettype wire

//--- hdl/priority_control.sv
// scheduler top that unpacks priorities, runs fixed and WRR pickers and registers one grant per cycle
`timescale 1ns/1ps
`default_nettype none

module priority_control (
    input  wire                     clk,
    input  wire                     rst_n,            // async, active high
    input  wire arb_pkg::req_vec_t  request_signals,
    input  wire arb_pkg::pri_bus_t  priorities,
    input  wire                     select_scheme,    // 0 fixed, 1 WRR
    output arb_pkg::port_idx_t      grant,
    output logic                    grant_vld
);

    import arb_pkg::*;

    pri_t      prio_arr [port_count];   // one value per port

    port_idx_t fp_grant;
    logic      fp_any;      // some port requests, in either mode
    port_idx_t wrr_grant;

    port_idx_t sel_grant;

    // port i lives at bits i*pri_w +: pri_w
    for (genvar i = 0; i < port_count; i++) begin : g_unpack
        assign prio_arr[i] = priorities[i*pri_w +: pri_w];
    end

    fixed_priority_pick u_fixed (
        .request_signals (request_signals),
        .prio            (prio_arr),
        .pick            (fp_grant),
        .any             (fp_any)
    );

    wrr_scheduler u_wrr (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable          (select_scheme),
        .request_signals (request_signals),
        .prio            (prio_arr),
        .pick            (wrr_grant),
        .any             ()
    );

    // mode select
    always_comb begin
        if (select_scheme) begin
            sel_grant = wrr_grant;
        end else begin
            sel_grant = fp_grant;
        end
    end

    // one cycle from sampled inputs to grant
    // grant is forced to 0 when nothing is requested
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            grant     <= '0;
            grant_vld <= 1'b0;
        end else begin
            grant_vld <= fp_any;
            grant     <= fp_any ? sel_grant : port_idx_t'(0);
        end
    end

endmodule : priority_control

`default_nettype wire

//--- bench/priority_control_sva.sv
// assertions on reset, grant legality and fixed-mode winner, bound into the scheduler top
`timescale 1ns/1ps
`default_nettype none

module priority_control_sva (
    input wire                     clk,
    input wire                     rst_n,
    input wire arb_pkg::req_vec_t  request_signals,
    input wire arb_pkg::pri_bus_t  priorities,
    input wire                     select_scheme,
    input wire arb_pkg::port_idx_t grant,
    input wire                     grant_vld
);

    import arb_pkg::*;

    req_vec_t req_q;          // inputs behind the current grant
    pri_bus_t pri_q;
    logic     mode_q;
    logic     higher_waiting; // some requester beat the granted port

    always_ff @(posedge clk) begin
        req_q  <= request_signals;
        pri_q  <= priorities;
        mode_q <= select_scheme;
    end

    always_comb begin
        higher_waiting = 1'b0;
        for (int i = 0; i < port_count; i++) begin
            if (req_q[i] && (pri_q[i*pri_w +: pri_w] > pri_q[int'(grant)*pri_w +: pri_w]))
                higher_waiting = 1'b1;
        end
    end

    a_quiet_in_reset : assert property (@(posedge clk) rst_n |-> !grant_vld)
        else $error("grant_vld set while reset is asserted");

    a_grant_requested : assert property (@(posedge clk) disable iff (rst_n)
        grant_vld |-> req_q[grant])
        else $error("grant given to a port that was not requesting");

    a_fixed_winner : assert property (@(posedge clk) disable iff (rst_n)
        (grant_vld && !mode_q) |-> !higher_waiting)
        else $error("fixed mode grant skipped a higher priority requester");

endmodule : priority_control_sva

bind priority_control priority_control_sva u_sva (
    .clk             (clk),
    .rst_n           (rst_n),
    .request_signals (request_signals),
    .priorities      (priorities),
    .select_scheme   (select_scheme),
    .grant           (grant),
    .grant_vld       (grant_vld)
);

`default_nettype wire

//--- bench/tb_priority_control.sv
// directed testbench that runs as top over the output scheduler and its bound assertions
`timescale 1ns/1ps
`default_nettype none

module tb_priority_control;

    import arb_pkg::*;

    localparam int max_cycles = 2000;   // tests need roughly 500 cycles

    logic      clk;
    logic      rst_n;
    req_vec_t  request_signals;
    pri_bus_t  priorities;
    logic      select_scheme;
    port_idx_t grant;
    logic      grant_vld;

    int errors;
    int checks;
    int cycle_cnt;
    int last_grant;     // grant seen after the latest step
    logic last_vld;

    // WRR reference state
    int   m_ptr;
    int   m_used;
    logic m_mode_q;

    priority_control uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .request_signals (request_signals),
        .priorities      (priorities),
        .select_scheme   (select_scheme),
        .grant           (grant),
        .grant_vld       (grant_vld)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        checks++;
        if (actual !== expected) begin
            $display("Fail %0t ns: %s, got %0d expected %0d", $time, msg, actual, expected);
            errors++;
        end
    endtask

    function automatic int prio_of(input pri_bus_t pri, input int p);
        return int'(pri[p*pri_w +: pri_w]);
    endfunction

    // max priority first, then the lowest port holding it
    function automatic int fixed_model(input req_vec_t req, input pri_bus_t pri);
        int best_pri;
        int winner;
        best_pri = -1;
        winner   = -1;
        for (int p = 0; p < port_count; p++) begin
            if (req[p] && prio_of(pri, p) > best_pri) best_pri = prio_of(pri, p);
        end
        for (int p = port_count - 1; p >= 0; p--) begin
            if (req[p] && prio_of(pri, p) == best_pri) winner = p;
        end
        return winner;
    endfunction

    // returns -1 when nobody asks and advances the reference state
    task automatic wrr_model_step(input req_vec_t req, input pri_bus_t pri, input logic mode,
                                  output int pick);
        int   cur;
        int   used;
        int   p;
        logic fresh;
        fresh = !mode || (mode != m_mode_q);
        cur   = fresh ? 0 : m_ptr;
        used  = fresh ? 0 : m_used;
        pick  = -1;
        if (req[cur] && used <= prio_of(pri, cur)) begin
            pick = cur;
            used = used + 1;
        end else begin
            for (int k = 1; k <= port_count && pick < 0; k++) begin
                p = (cur + k) % port_count;     // wraps back onto cur last
                if (req[p]) pick = p;
            end
            if (pick >= 0) begin
                cur  = pick;
                used = 1;
            end
        end
        m_mode_q = mode;
        if (mode) begin
            m_ptr  = cur;
            m_used = used;
        end else begin
            m_ptr  = 0;
            m_used = 0;
        end
    endtask

    // drive on the falling edge, check one cycle later
    task automatic step(input req_vec_t req, input pri_bus_t pri, input logic mode,
                        input string tag);
        int exp_fixed;
        int exp_wrr;
        int exp_idx;
        @(negedge clk);
        request_signals = req;
        priorities      = pri;
        select_scheme   = mode;
        exp_fixed = fixed_model(req, pri);
        wrr_model_step(req, pri, mode, exp_wrr);
        exp_idx = mode ? exp_wrr : exp_fixed;
        @(posedge clk);
        #1;
        check_eq(32'(grant_vld), (exp_idx >= 0) ? 32'd1 : 32'd0, {tag, " grant_vld"});
        check_eq(32'(grant), (exp_idx >= 0) ? 32'(exp_idx) : 32'd0, {tag, " grant"});
        last_grant = int'(grant);
        last_vld   = grant_vld;
    endtask

    task automatic reset_and_idle();
        repeat (16) begin
            @(posedge clk);
            #1;
            check_eq(32'(grant_vld), 32'd0, "grant_vld in reset");
            check_eq(32'(grant), 32'd0, "grant in reset");
        end
        @(negedge clk);
        rst_n           = 1'b0;     // release
        request_signals = '0;
        repeat (4) step('0, 32'h89ab_cdef, 1'b0, "idle fixed");
        repeat (4) step('0, 32'h89ab_cdef, 1'b1, "idle wrr");
    endtask

    task automatic fixed_priority_cases();
        step(8'b0001_0000, 32'h1111_1111, 1'b0, "single requester");
        check_eq(32'(last_grant), 32'd4, "single requester port");
        step(8'hff, 32'h0c45_3210, 1'b0, "distinct max");
        check_eq(32'(last_grant), 32'd6, "distinct max port");
        step(8'hff, 32'h9239_1290, 1'b0, "tie");
        check_eq(32'(last_grant), 32'd1, "tie goes low");
        step(8'b1010_1000, 32'h0000_0000, 1'b0, "all zero");
        check_eq(32'(last_grant), 32'd3, "all zero lowest requester");
        step(8'b0000_0110, 32'h0000_035f, 1'b0, "max unrequested");   // port 0 idle with F
        check_eq(32'(last_grant), 32'd1, "unrequested max ignored");
        for (int i = 0; i < 200; i++) begin
            step(req_vec_t'($urandom), pri_bus_t'($urandom), 1'b0, "fixed random");
        end
    endtask

    task automatic wrr_weight_sequence();
        int cnt5;
        cnt5 = 0;
        // p0 w0, p2 w1, p5 w3, rest w2
        for (int i = 0; i < 60; i++) begin
            step(8'hff, 32'h2232_2120, 1'b1, "wrr weights");
            if (last_vld && last_grant == 5) cnt5++;
        end
        check_eq(32'(cnt5), 32'd12, "port 5 grants in 60 cycles");
    endtask

    task automatic wrr_sparse_requests();
        repeat (12) step(8'b0100_0101, 32'h0000_0000, 1'b1, "wrr sparse");
        repeat (8) begin
            step(8'b0000_1000, 32'h0000_1000, 1'b1, "wrr lone");
            check_eq(32'(last_grant), 32'd3, "lone requester kept");
        end
        step(8'b0000_0010, 32'h0000_0030, 1'b1, "wrr turn start");
        step(8'b0001_0010, 32'h0000_0030, 1'b1, "wrr turn hold");
        check_eq(32'(last_grant), 32'd1, "turn held by port 1");
        step(8'b0001_0000, 32'h0000_0030, 1'b1, "wrr drop");
        check_eq(32'(last_grant), 32'd4, "grant moves after drop");
        repeat (2) step(8'b0001_0010, 32'h0000_0030, 1'b1, "wrr after drop");
    endtask

    task automatic mode_switching();
        logic mode;
        repeat (4) step(8'hff, 32'h2232_2120, 1'b0, "switch fixed");
        check_eq(32'(last_grant), 32'd5, "fixed before switch");
        step(8'hff, 32'h2232_2120, 1'b1, "switch to wrr");
        check_eq(32'(last_grant), 32'd0, "wrr restarts at port 0");
        step(8'hff, 32'h2232_2120, 1'b1, "wrr second");
        check_eq(32'(last_grant), 32'd1, "wrr moves on");
        step(8'hff, 32'h2232_2120, 1'b0, "switch back");
        check_eq(32'(last_grant), 32'd5, "fixed right after switch back");
        mode = 1'b0;
        for (int i = 0; i < 150; i++) begin
            if (($urandom % 8) == 0) mode = !mode;
            step(req_vec_t'($urandom), pri_bus_t'($urandom), mode, "mixed random");
        end
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        errors          = 0;
        checks          = 0;
        last_grant      = 0;
        last_vld        = 1'b0;
        m_ptr           = 0;
        m_used          = 0;
        m_mode_q        = 1'b0;
        void'($urandom(32'h2d9c_e259));
        rst_n           = 1'b1;             // reset asserted
        request_signals = 8'hff;            // requests pending during reset
        priorities      = 32'h7654_3210;
        select_scheme   = 1'b0;

        reset_and_idle();
        fixed_priority_cases();
        wrr_weight_sequence();
        wrr_sparse_requests();
        mode_switching();

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_priority_control

`default_nettype wire

//--- sim.f
hdl/arb_pkg.sv
hdl/fixed_priority_pick.sv
hdl/wrr_scheduler.sv
hdl/priority_control.sv
bench/priority_control_sva.sv
bench/tb_priority_control.sv

//--- run.sh
#!/bin/sh
# Build and run the scheduler testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --top-module tb_priority_control \
    -f sim.f \
    -o sim_tb

# tee keeps the pipeline status at zero so the log search below decides
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
